// File: source/rdma_proto_pkg.sv
package rdma_proto_pkg;

  ////////////////////////////////////////////////////////////
  // Field widths
  ////////////////////////////////////////////////////////////

  localparam int OPCODE_BITS = 5;
  localparam int MODE_BITS = 1;

  ////////////////////////////////////////////////////////////
  // Host request opcodes
  ////////////////////////////////////////////////////////////

  // Read is never parsed on this path
  localparam logic [OPCODE_BITS-1:0] APP_READ = 5'h01;
  localparam logic [OPCODE_BITS-1:0] APP_WRITE = 5'h02;
  localparam logic [OPCODE_BITS-1:0] APP_SEND = 5'h03;

  ////////////////////////////////////////////////////////////
  // RC wire opcodes, low 5 bits of the IB encoding
  ////////////////////////////////////////////////////////////

  localparam logic [OPCODE_BITS-1:0] RC_SEND_FIRST = 5'h00;
  localparam logic [OPCODE_BITS-1:0] RC_SEND_MIDDLE = 5'h01;
  localparam logic [OPCODE_BITS-1:0] RC_SEND_LAST = 5'h02;
  localparam logic [OPCODE_BITS-1:0] RC_SEND_ONLY = 5'h04;
  localparam logic [OPCODE_BITS-1:0] RC_RDMA_WRITE_FIRST = 5'h06;
  localparam logic [OPCODE_BITS-1:0] RC_RDMA_WRITE_MIDDLE = 5'h07;
  localparam logic [OPCODE_BITS-1:0] RC_RDMA_WRITE_LAST = 5'h08;
  localparam logic [OPCODE_BITS-1:0] RC_RDMA_WRITE_ONLY = 5'h0a;

  // Transfer mode
  localparam logic [MODE_BITS-1:0] RDMA_MODE_PARSE = 1'b0;
  localparam logic [MODE_BITS-1:0] RDMA_MODE_RAW = 1'b1;

endpackage

// File: source/dreq_pkg.sv
package dreq_pkg;

  import rdma_proto_pkg::*;

  localparam int VADDR_BITS = 48;
  localparam int LEN_BITS = 28;
  localparam int PID_BITS = 6;
  localparam int DEST_BITS = 4;
  localparam int STRM_BITS = 2;

  // Local part of a host request
  typedef struct packed {
    logic [OPCODE_BITS-1:0] opcode;
    logic [MODE_BITS-1:0] mode;
    logic rdma;
    logic remote;
    logic [PID_BITS-1:0] pid;
    logic [DEST_BITS-1:0] dest;
    logic [STRM_BITS-1:0] strm;
    logic last;
    logic host;
    logic actv;
    logic [VADDR_BITS-1:0] vaddr;
    logic [LEN_BITS-1:0] len;
  } req_t;

  // Remote part, target address only
  typedef struct packed {
    logic [VADDR_BITS-1:0] vaddr;
    logic [DEST_BITS-1:0] dest;
    logic [STRM_BITS-1:0] strm;
  } req_rem_t;

  typedef struct packed {
    req_t req_1;
    req_rem_t req_2;
  } dreq_t;

endpackage

// File: source/dreq_queue.sv
`timescale 1ns/10ps

module dreq_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic            aclk,
  input  logic            aresetn,

  input  logic            s_valid,
  output logic            s_ready,
  input  dreq_pkg::dreq_t s_data,

  output logic            m_valid,
  input  logic            m_ready,
  output dreq_pkg::dreq_t m_data
);

  import dreq_pkg::*;

  localparam int PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam logic [PTR_BITS:0] CNT_FULL = (PTR_BITS + 1)'(QUEUE_DEPTH);
  localparam logic [PTR_BITS:0] CNT_ONE = (PTR_BITS + 1)'(1);
  localparam logic [PTR_BITS-1:0] PTR_ONE = PTR_BITS'(1);

  dreq_t mem [QUEUE_DEPTH];

  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [PTR_BITS:0] count;
  logic push;
  logic pop;

  // Flags come straight from the occupancy count
  assign s_ready = (count != CNT_FULL);
  assign m_valid = (count != '0);
  assign m_data = mem[rd_ptr];

  assign push = s_valid & s_ready;
  assign pop = m_valid & m_ready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + PTR_ONE;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + PTR_ONE;
      end
      case ({push, pop})
        2'b10: count <= count + CNT_ONE;
        2'b01: count <= count - CNT_ONE;
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= s_data;
    end
  end

endmodule

// File: source/meta_reg.sv
`timescale 1ns/10ps

module meta_reg (
  input  logic            aclk,
  input  logic            aresetn,

  input  logic            s_valid,
  output logic            s_ready,
  input  dreq_pkg::dreq_t s_data,

  output logic            m_valid,
  input  logic            m_ready,
  output dreq_pkg::dreq_t m_data
);

  import dreq_pkg::*;

  logic main_valid;
  logic spare_valid;
  dreq_t main_data;
  dreq_t spare_data;
  logic main_free;

  // Main entry empties when it is unused or taken this cycle
  assign main_free = !main_valid || m_ready;

  // Ready only looks at a flop, spare empty means room
  assign s_ready = !spare_valid;
  assign m_valid = main_valid;
  assign m_data = main_data;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      main_valid <= 1'b0;
      spare_valid <= 1'b0;
    end else if (main_free) begin
      if (spare_valid) begin
        main_valid <= 1'b1;
        spare_valid <= 1'b0;
      end else begin
        main_valid <= s_valid;
      end
    end else if (s_valid && s_ready) begin
      // Stalled with a word arriving, park it
      spare_valid <= 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (main_free) begin
      main_data <= spare_valid ? spare_data : s_data;
    end else if (s_valid && s_ready) begin
      spare_data <= s_data;
    end
  end

endmodule

// File: source/dreq_rdma_parser_wr.sv
`timescale 1ns/10ps

module dreq_rdma_parser_wr #(
  parameter int PMTU_BYTES = 1024
) (
  input  logic            aclk,
  input  logic            aresetn,

  input  logic            s_req_valid,
  output logic            s_req_ready,
  input  dreq_pkg::dreq_t s_req_data,

  output logic            m_req_valid,
  input  logic            m_req_ready,
  output dreq_pkg::dreq_t m_req_data
);

  import rdma_proto_pkg::*;
  import dreq_pkg::*;

  localparam logic [LEN_BITS-1:0] PMTU_LEN = LEN_BITS'(PMTU_BYTES);
  localparam logic [VADDR_BITS-1:0] PMTU_VADDR = VADDR_BITS'(PMTU_BYTES);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_PARSE_WRITE_FIRST, ST_PARSE_WRITE, ST_SEND_WRITE,
    ST_PARSE_SEND_FIRST, ST_PARSE_SEND, ST_SEND_SEND,
    ST_SEND_BASE
  } state_t;

  state_t state_c, state_n;

  // Working copy of the request, shrinks as packets are cut
  req_t req_1_c, req_1_n;
  req_rem_t req_2_c, req_2_n;

  // Current packet command
  logic [OPCODE_BITS-1:0] pop_c, pop_n;
  logic plast_c, plast_n;
  logic [VADDR_BITS-1:0] plvaddr_c, plvaddr_n;
  logic [VADDR_BITS-1:0] prvaddr_c, prvaddr_n;
  logic [LEN_BITS-1:0] plen_c, plen_n;

  logic parse_wr;
  logic parse_first;
  logic fits;

  logic parsed_valid;
  logic parsed_ready;
  dreq_t parsed_data;

  // Pick the RC opcode for one packet
  function automatic logic [OPCODE_BITS-1:0] rc_opcode(input logic wr, input logic first,
                                                       input logic fit);
    logic [OPCODE_BITS-1:0] op;
    if (wr) begin
      if (first) begin
        op = fit ? RC_RDMA_WRITE_ONLY : RC_RDMA_WRITE_FIRST;
      end else begin
        op = fit ? RC_RDMA_WRITE_LAST : RC_RDMA_WRITE_MIDDLE;
      end
    end else begin
      if (first) begin
        op = fit ? RC_SEND_ONLY : RC_SEND_FIRST;
      end else begin
        op = fit ? RC_SEND_LAST : RC_SEND_MIDDLE;
      end
    end
    return op;
  endfunction

  assign parse_wr = (state_c == ST_PARSE_WRITE_FIRST) || (state_c == ST_PARSE_WRITE);
  assign parse_first = (state_c == ST_PARSE_WRITE_FIRST) || (state_c == ST_PARSE_SEND_FIRST);
  assign fits = (req_1_c.len <= PMTU_LEN);

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state_c <= ST_IDLE;
    end else begin
      state_c <= state_n;
    end
  end

  always_ff @(posedge aclk) begin
    req_1_c <= req_1_n;
    req_2_c <= req_2_n;
    pop_c <= pop_n;
    plast_c <= plast_n;
    plvaddr_c <= plvaddr_n;
    prvaddr_c <= prvaddr_n;
    plen_c <= plen_n;
  end

  ////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_n = state_c;
    case (state_c)
      ST_IDLE: begin
        if (s_req_valid) begin
          if (s_req_data.req_1.mode == RDMA_MODE_RAW) begin
            state_n = ST_SEND_BASE;
          end else if (s_req_data.req_1.opcode == APP_WRITE) begin
            state_n = ST_PARSE_WRITE_FIRST;
          end else if (s_req_data.req_1.opcode == APP_SEND) begin
            state_n = ST_PARSE_SEND_FIRST;
          end
          // Anything else is consumed here and dropped
        end
      end
      ST_PARSE_WRITE_FIRST, ST_PARSE_WRITE: state_n = ST_SEND_WRITE;
      ST_SEND_WRITE: begin
        if (parsed_ready) begin
          state_n = (req_1_c.len != '0) ? ST_PARSE_WRITE : ST_IDLE;
        end
      end
      ST_PARSE_SEND_FIRST, ST_PARSE_SEND: state_n = ST_SEND_SEND;
      ST_SEND_SEND: begin
        if (parsed_ready) begin
          state_n = (req_1_c.len != '0) ? ST_PARSE_SEND : ST_IDLE;
        end
      end
      ST_SEND_BASE: begin
        if (parsed_ready) begin
          state_n = ST_IDLE;
        end
      end
      default: state_n = ST_IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  always_comb begin
    req_1_n = req_1_c;
    req_2_n = req_2_c;
    pop_n = pop_c;
    plast_n = plast_c;
    plvaddr_n = plvaddr_c;
    prvaddr_n = prvaddr_c;
    plen_n = plen_c;
    s_req_ready = 1'b0;
    parsed_valid = 1'b0;

    case (state_c)
      ST_IDLE: begin
        s_req_ready = 1'b1;
        if (s_req_valid) begin
          req_1_n = s_req_data.req_1;
          req_2_n = s_req_data.req_2;
        end
      end
      ST_PARSE_WRITE_FIRST, ST_PARSE_WRITE, ST_PARSE_SEND_FIRST, ST_PARSE_SEND: begin
        plvaddr_n = req_1_c.vaddr;
        // Sends carry no remote address
        prvaddr_n = parse_wr ? req_2_c.vaddr : '0;
        pop_n = rc_opcode(parse_wr, parse_first, fits);
        if (fits) begin
          req_1_n.len = '0;
          plen_n = req_1_c.len;
          plast_n = req_1_c.last;
        end else begin
          req_1_n.vaddr = req_1_c.vaddr + PMTU_VADDR;
          if (parse_wr) begin
            req_2_n.vaddr = req_2_c.vaddr + PMTU_VADDR;
          end
          req_1_n.len = req_1_c.len - PMTU_LEN;
          plen_n = PMTU_LEN;
          plast_n = 1'b0;
        end
      end
      ST_SEND_WRITE, ST_SEND_SEND, ST_SEND_BASE: parsed_valid = 1'b1;
      default: parsed_valid = 1'b0;
    endcase
  end

  // Command out, raw requests go as they came in
  always_comb begin
    if (state_c == ST_SEND_BASE) begin
      parsed_data.req_1 = req_1_c;
      parsed_data.req_2 = req_2_c;
    end else begin
      parsed_data.req_1.opcode = pop_c;
      parsed_data.req_1.mode = req_1_c.mode;
      parsed_data.req_1.rdma = 1'b1;
      parsed_data.req_1.remote = 1'b1;
      parsed_data.req_1.pid = req_1_c.pid;
      parsed_data.req_1.dest = req_1_c.dest;
      parsed_data.req_1.strm = req_1_c.strm;
      parsed_data.req_1.last = plast_c;
      parsed_data.req_1.host = req_1_c.host;
      parsed_data.req_1.actv = 1'b1;
      parsed_data.req_1.vaddr = plvaddr_c;
      parsed_data.req_1.len = plen_c;
      parsed_data.req_2.vaddr = prvaddr_c;
      parsed_data.req_2.dest = req_2_c.dest;
      parsed_data.req_2.strm = req_2_c.strm;
    end
  end

  // Output slice toward the packet generator
  meta_reg inst_reg_out (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (parsed_valid),
    .s_ready (parsed_ready),
    .s_data  (parsed_data),
    .m_valid (m_req_valid),
    .m_ready (m_req_ready),
    .m_data  (m_req_data)
  );

endmodule

// File: source/rdma_wr_path.sv
`timescale 1ns/10ps

module rdma_wr_path #(
  parameter int PMTU_BYTES = 1024,
  parameter int QUEUE_DEPTH = 4
) (
  input  logic            aclk,
  input  logic            aresetn,

  input  logic            s_req_valid,
  output logic            s_req_ready,
  input  dreq_pkg::dreq_t s_req_data,

  output logic            m_req_valid,
  input  logic            m_req_ready,
  output dreq_pkg::dreq_t m_req_data
);

  // Queue to parser
  logic q_valid;
  logic q_ready;
  dreq_pkg::dreq_t q_data;

  dreq_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) inst_queue (
    .aclk    (aclk),
    .aresetn (aresetn),
    .s_valid (s_req_valid),
    .s_ready (s_req_ready),
    .s_data  (s_req_data),
    .m_valid (q_valid),
    .m_ready (q_ready),
    .m_data  (q_data)
  );

  dreq_rdma_parser_wr #(
    .PMTU_BYTES (PMTU_BYTES)
  ) inst_parser (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .s_req_valid (q_valid),
    .s_req_ready (q_ready),
    .s_req_data  (q_data),
    .m_req_valid (m_req_valid),
    .m_req_ready (m_req_ready),
    .m_req_data  (m_req_data)
  );

endmodule

// File: test/rdma_wr_path_assert.sv
`timescale 1ns/10ps

module rdma_wr_path_assert #(
  parameter int PMTU_BYTES = 1024
) (
  input logic            aclk,
  input logic            aresetn,
  input logic            m_req_valid,
  input logic            m_req_ready,
  input dreq_pkg::dreq_t m_req_data
);

  import rdma_proto_pkg::*;
  import dreq_pkg::*;

  localparam logic [LEN_BITS-1:0] PMTU_LEN = LEN_BITS'(PMTU_BYTES);

  // Number of assertion failures so far
  int unsigned fail_count = 0;

  // Stalled output holds valid and its word
  a_stall_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    (m_req_valid && !m_req_ready) |=> (m_req_valid && $stable(m_req_data)))
    else begin
      fail_count++;
      $error("m_req_valid or m_req_data changed while the output was stalled");
    end

  a_reset_idle: assert property (@(posedge aclk)
    !aresetn |=> !m_req_valid)
    else begin
      fail_count++;
      $error("m_req_valid high in the cycle after reset");
    end

  // Parsed commands never exceed one MTU
  a_len_pmtu: assert property (@(posedge aclk) disable iff (!aresetn)
    (m_req_valid && m_req_data.req_1.mode == RDMA_MODE_PARSE) |->
      (m_req_data.req_1.len <= PMTU_LEN))
    else begin
      fail_count++;
      $error("parsed command length above the path MTU");
    end

endmodule

bind rdma_wr_path rdma_wr_path_assert #(
  .PMTU_BYTES (PMTU_BYTES)
) inst_assert (
  .aclk        (aclk),
  .aresetn     (aresetn),
  .m_req_valid (m_req_valid),
  .m_req_ready (m_req_ready),
  .m_req_data  (m_req_data)
);

// File: test/tb_rdma_wr_path.sv
`timescale 1ns/10ps

module tb_rdma_wr_path;

  import rdma_proto_pkg::*;
  import dreq_pkg::*;

  localparam int PMTU_BYTES = 256;
  localparam int NUM_REQS = 200;
  localparam int ACCEPT_LIMIT = 2000;
  localparam int DRAIN_LIMIT = 5000;
  localparam logic [LEN_BITS-1:0] PMTU_LEN = LEN_BITS'(PMTU_BYTES);
  localparam logic [VADDR_BITS-1:0] PMTU_VADDR = VADDR_BITS'(PMTU_BYTES);

  logic aclk;
  logic aresetn;
  logic s_req_valid;
  logic s_req_ready;
  dreq_t s_req_data;
  logic m_req_valid;
  logic m_req_ready;
  dreq_t m_req_data;

  // Expected commands in output order
  dreq_t expq[$];
  int err_count;
  int assert_count;
  int timeout_count;
  int got_count;
  int exp_total;

  rdma_wr_path #(
    .PMTU_BYTES  (PMTU_BYTES),
    .QUEUE_DEPTH (4)
  ) DUT (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .s_req_valid (s_req_valid),
    .s_req_ready (s_req_ready),
    .s_req_data  (s_req_data),
    .m_req_valid (m_req_valid),
    .m_req_ready (m_req_ready),
    .m_req_data  (m_req_data)
  );

  always #50 aclk = ~aclk;

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  task automatic add_expected(input dreq_t d);
    dreq_t e;
    logic [LEN_BITS-1:0] left;
    logic [VADDR_BITS-1:0] laddr;
    logic [VADDR_BITS-1:0] raddr;
    bit is_wr;
    bit first;
    bit done;
    if (d.req_1.mode == RDMA_MODE_RAW) begin
      expq.push_back(d);
      exp_total++;
    end else if (d.req_1.opcode == APP_WRITE || d.req_1.opcode == APP_SEND) begin
      is_wr = (d.req_1.opcode == APP_WRITE);
      left = d.req_1.len;
      laddr = d.req_1.vaddr;
      // Sends have no remote address
      raddr = is_wr ? d.req_2.vaddr : '0;
      first = 1'b1;
      done = 1'b0;
      while (!done) begin
        e = d;
        e.req_1.rdma = 1'b1;
        e.req_1.remote = 1'b1;
        e.req_1.actv = 1'b1;
        e.req_1.vaddr = laddr;
        e.req_2.vaddr = raddr;
        if (left > PMTU_LEN) begin
          e.req_1.len = PMTU_LEN;
          e.req_1.last = 1'b0;
          if (is_wr)
            e.req_1.opcode = first ? RC_RDMA_WRITE_FIRST : RC_RDMA_WRITE_MIDDLE;
          else
            e.req_1.opcode = first ? RC_SEND_FIRST : RC_SEND_MIDDLE;
          left = left - PMTU_LEN;
          laddr = laddr + PMTU_VADDR;
          if (is_wr)
            raddr = raddr + PMTU_VADDR;
        end else begin
          e.req_1.len = left;
          e.req_1.last = d.req_1.last;
          if (is_wr)
            e.req_1.opcode = first ? RC_RDMA_WRITE_ONLY : RC_RDMA_WRITE_LAST;
          else
            e.req_1.opcode = first ? RC_SEND_ONLY : RC_SEND_LAST;
          done = 1'b1;
        end
        expq.push_back(e);
        exp_total++;
        first = 1'b0;
      end
    end
    // Parse-mode reads leave nothing behind
  endtask

  ////////////////////////////////////////////////////////////
  // Scoreboard
  ////////////////////////////////////////////////////////////

  task automatic check_field(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("ERR %0t: command %0d field %s got %0h expected %0h",
               $time, got_count, name, got, exp);
    end
  endtask

  task automatic check_output();
    dreq_t exp;
    got_count++;
    if (expq.size() == 0) begin
      err_count++;
      $display("ERR %0t: unexpected command %0d with opcode %0h",
               $time, got_count, m_req_data.req_1.opcode);
    end else begin
      exp = expq.pop_front();
      check_field("opcode", 64'(m_req_data.req_1.opcode), 64'(exp.req_1.opcode));
      check_field("mode", 64'(m_req_data.req_1.mode), 64'(exp.req_1.mode));
      check_field("rdma", 64'(m_req_data.req_1.rdma), 64'(exp.req_1.rdma));
      check_field("remote", 64'(m_req_data.req_1.remote), 64'(exp.req_1.remote));
      check_field("pid", 64'(m_req_data.req_1.pid), 64'(exp.req_1.pid));
      check_field("dest", 64'(m_req_data.req_1.dest), 64'(exp.req_1.dest));
      check_field("strm", 64'(m_req_data.req_1.strm), 64'(exp.req_1.strm));
      check_field("last", 64'(m_req_data.req_1.last), 64'(exp.req_1.last));
      check_field("host", 64'(m_req_data.req_1.host), 64'(exp.req_1.host));
      check_field("actv", 64'(m_req_data.req_1.actv), 64'(exp.req_1.actv));
      check_field("vaddr", 64'(m_req_data.req_1.vaddr), 64'(exp.req_1.vaddr));
      check_field("len", 64'(m_req_data.req_1.len), 64'(exp.req_1.len));
      check_field("rem vaddr", 64'(m_req_data.req_2.vaddr), 64'(exp.req_2.vaddr));
      check_field("rem dest", 64'(m_req_data.req_2.dest), 64'(exp.req_2.dest));
      check_field("rem strm", 64'(m_req_data.req_2.strm), 64'(exp.req_2.strm));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Outputs only move on the edge, so a transfer is known before it
  task automatic next_cycle();
    if (m_req_valid === 1'b1 && m_req_ready === 1'b1)
      check_output();
    @(posedge aclk);
    #1;
    m_req_ready = ($urandom_range(0, 99) < 70);
  endtask

  function automatic dreq_t random_request();
    dreq_t d;
    int unsigned pick;
    pick = $urandom_range(0, 99);
    if (pick < 45)
      d.req_1.opcode = APP_WRITE;
    else if (pick < 90)
      d.req_1.opcode = APP_SEND;
    else
      d.req_1.opcode = APP_READ;
    d.req_1.mode = ($urandom_range(0, 9) == 0) ? RDMA_MODE_RAW : RDMA_MODE_PARSE;
    d.req_1.rdma = 1'($urandom());
    d.req_1.remote = 1'($urandom());
    d.req_1.pid = PID_BITS'($urandom());
    d.req_1.dest = DEST_BITS'($urandom());
    d.req_1.strm = STRM_BITS'($urandom());
    d.req_1.last = 1'($urandom());
    d.req_1.host = 1'($urandom());
    d.req_1.actv = 1'($urandom());
    d.req_1.vaddr = {16'($urandom()), $urandom()};
    // Exact multiples of the MTU now and then
    if ($urandom_range(0, 3) == 0)
      d.req_1.len = LEN_BITS'(256 * $urandom_range(0, 4));
    else
      d.req_1.len = LEN_BITS'($urandom_range(0, 1100));
    d.req_2.vaddr = {16'($urandom()), $urandom()};
    d.req_2.dest = DEST_BITS'($urandom());
    d.req_2.strm = STRM_BITS'($urandom());
    return d;
  endfunction

  task automatic send_request(input dreq_t d, input int idx);
    int waited;
    bit accepted;
    waited = 0;
    accepted = 1'b0;
    s_req_valid = 1'b1;
    s_req_data = d;
    while (!accepted && waited < ACCEPT_LIMIT) begin
      if (s_req_ready) begin
        accepted = 1'b1;
        add_expected(d);
      end
      next_cycle();
      waited++;
    end
    if (!accepted) begin
      timeout_count++;
      $display("Timeout: request %0d was not accepted within %0d cycles", idx, ACCEPT_LIMIT);
    end
  endtask

  initial begin
    dreq_t d;
    int gap;
    int waited;
    aclk = 1'b0;
    aresetn = 1'b0;
    s_req_valid = 1'b0;
    s_req_data = '0;
    m_req_ready = 1'b0;
    err_count = 0;
    assert_count = 0;
    timeout_count = 0;
    got_count = 0;
    exp_total = 0;
    void'($urandom(12652));

    repeat (4) next_cycle();
    aresetn = 1'b1;

    for (int i = 0; i < NUM_REQS && timeout_count == 0; i++) begin
      d = random_request();
      send_request(d, i);
      if ($urandom_range(0, 9) < 3) begin
        gap = $urandom_range(1, 3);
        s_req_valid = 1'b0;
        repeat (gap) next_cycle();
      end
    end
    s_req_valid = 1'b0;

    // Drain whatever the model still expects
    waited = 0;
    while (expq.size() != 0 && waited < DRAIN_LIMIT && timeout_count == 0) begin
      next_cycle();
      waited++;
    end
    if (expq.size() != 0) begin
      timeout_count++;
      $display("Timeout: %0d commands never came out of the DUT", expq.size());
    end
    // A few more cycles to catch stray commands
    repeat (20) next_cycle();

    if (got_count != exp_total) begin
      err_count++;
      $display("ERR %0t: saw %0d commands, model expects %0d", $time, got_count, exp_total);
    end
    assert_count = DUT.inst_assert.fail_count;
    $display("Summary: %0d value errors, %0d assertion failures, %0d timeouts, %0d/%0d commands",
             err_count, assert_count, timeout_count, got_count, exp_total);
    if (err_count == 0 && assert_count == 0 && timeout_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: flist.f
source/rdma_proto_pkg.sv
source/dreq_pkg.sv
source/dreq_queue.sv
source/meta_reg.sv
source/dreq_rdma_parser_wr.sv
source/rdma_wr_path.sv
test/rdma_wr_path_assert.sv
test/tb_rdma_wr_path.sv

// File: Makefile
TOP := tb_rdma_wr_path
SIM := obj_dir/V$(TOP)
SRCS := $(shell cat flist.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): flist.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || (cat sim.log; false)
	cat sim.log
	! grep -q "TB FAILED" sim.log

clean:
	rm -rf obj_dir sim.log
